/* source/axi_dw_pkg.sv */
// Shared widths, AXI field types, response codes and channel structs for the AXI downsizer
`default_nettype none

package axi_dw_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  // Byte address width on both sides
  localparam int unsigned addr_width = 16;
  // Default data widths, picked up by the top level
  localparam int unsigned wide_data_width   = 64;
  localparam int unsigned narrow_data_width = 32;

  // ----------------------------------------
  // AXI field types
  // ----------------------------------------

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [3:0]            id_t;
  // Beat count minus one
  typedef logic [7:0]            len_t;
  // Log2 of bytes per beat
  typedef logic [2:0]            size_t;
  typedef logic [1:0]            burst_t;
  typedef logic [3:0]            cache_t;
  typedef logic [1:0]            resp_t;

  // Burst types
  localparam burst_t burst_fixed = 2'b00;
  localparam burst_t burst_incr  = 2'b01;
  localparam burst_t burst_wrap  = 2'b10;

  // Response codes
  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

  // ----------------------------------------
  // Channel structs
  // ----------------------------------------

  // Read and write address channels share one layout
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
    logic   valid;
  } ax_req_t;

  // Write data beats
  typedef struct packed {
    logic [wide_data_width-1:0]   data;
    logic [wide_data_width/8-1:0] strb;
    logic                         last;
    logic                         valid;
  } wide_w_t;

  typedef struct packed {
    logic [narrow_data_width-1:0]   data;
    logic [narrow_data_width/8-1:0] strb;
    logic                           last;
    logic                           valid;
  } narrow_w_t;

  // Read data beats
  typedef struct packed {
    id_t                        id;
    logic [wide_data_width-1:0] data;
    resp_t                      resp;
    logic                       last;
    logic                       valid;
  } wide_r_t;

  typedef struct packed {
    id_t                          id;
    logic [narrow_data_width-1:0] data;
    resp_t                        resp;
    logic                         last;
    logic                         valid;
  } narrow_r_t;

  // Write response, same on both sides
  typedef struct packed {
    id_t   id;
    resp_t resp;
    logic  valid;
  } b_rsp_t;

endpackage

`default_nettype wire

/* source/axi_dw_read_path.sv */
// Read side of the downsizer; forwards AR and steers narrow R data into its wide lane
`default_nettype none

module axi_dw_read_path
  import axi_dw_pkg::*;
#(
  parameter int unsigned wide_data_width   = axi_dw_pkg::wide_data_width,
  parameter int unsigned narrow_data_width = axi_dw_pkg::narrow_data_width
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Wide manager side
  input  ax_req_t   wide_ar,
  output logic      wide_ar_ready,
  output wide_r_t   wide_r,
  input  logic      wide_r_ready,
  // Narrow subordinate side
  output ax_req_t   narrow_ar,
  input  logic      narrow_ar_ready,
  input  narrow_r_t narrow_r,
  output logic      narrow_r_ready
);

  // Byte offset bits within one narrow word
  localparam int unsigned word_lsb  = $clog2(narrow_data_width / 8);
  // Bits that pick the narrow lane inside a wide beat
  localparam int unsigned lane_bits = $clog2(wide_data_width / narrow_data_width);

  typedef enum logic {
    st_idle,
    st_single
  } state_e;

  state_e state_d, state_q;

  // Lane of the outstanding read
  logic [lane_bits-1:0] lane_q;

  logic ar_fire;
  logic r_fire;

  // ----------------------------------------
  // Address channel
  // ----------------------------------------

  always_comb begin
    narrow_ar       = wide_ar;
    // Align down to a narrow word
    narrow_ar.addr  = {wide_ar.addr[addr_width-1:word_lsb], {word_lsb{1'b0}}};
    narrow_ar.size  = size_t'(word_lsb);
    // No new request while a beat is outstanding
    narrow_ar.valid = wide_ar.valid && (state_q == st_idle);
    wide_ar_ready   = narrow_ar_ready && (state_q == st_idle);
  end

  assign ar_fire = wide_ar.valid && wide_ar_ready;

  // ----------------------------------------
  // Read data steering
  // ----------------------------------------

  always_comb begin
    // Unused lanes read as zero
    wide_r         = '0;
    wide_r.id      = narrow_r.id;
    wide_r.resp    = narrow_r.resp;
    wide_r.last    = narrow_r.last;
    narrow_r_ready = 1'b0;
    if (state_q == st_single) begin
      wide_r.data[lane_q*narrow_data_width +: narrow_data_width] = narrow_r.data;
      wide_r.valid   = narrow_r.valid;
      narrow_r_ready = wide_r_ready;
    end
  end

  assign r_fire = wide_r.valid && wide_r_ready;

  // ----------------------------------------
  // FSM
  // ----------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (ar_fire) begin
          state_d = st_single;
        end
      end
      st_single: begin
        // Beat delivered, back to idle
        if (r_fire) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Lane captured with the request address
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      lane_q <= wide_ar.addr[word_lsb +: lane_bits];
    end
  end

endmodule

`default_nettype wire

/* source/axi_dw_write_path.sv */
// Write side of the downsizer; forwards AW and selects the addressed lane of W data and strobes
`default_nettype none

module axi_dw_write_path
  import axi_dw_pkg::*;
#(
  parameter int unsigned wide_data_width   = axi_dw_pkg::wide_data_width,
  parameter int unsigned narrow_data_width = axi_dw_pkg::narrow_data_width
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Wide manager side
  input  ax_req_t   wide_aw,
  output logic      wide_aw_ready,
  input  wide_w_t   wide_w,
  output logic      wide_w_ready,
  output b_rsp_t    wide_b,
  input  logic      wide_b_ready,
  // Narrow subordinate side
  output ax_req_t   narrow_aw,
  input  logic      narrow_aw_ready,
  output narrow_w_t narrow_w,
  input  logic      narrow_w_ready,
  input  b_rsp_t    narrow_b,
  output logic      narrow_b_ready
);

  // Byte offset bits within one narrow word
  localparam int unsigned word_lsb    = $clog2(narrow_data_width / 8);
  // Lane select bits and strobe bits per lane
  localparam int unsigned lane_bits   = $clog2(wide_data_width / narrow_data_width);
  localparam int unsigned narrow_strb = narrow_data_width / 8;

  typedef enum logic {
    st_idle,
    st_single
  } state_e;

  state_e state_d, state_q;

  // Lane of the accepted write address
  logic [lane_bits-1:0] lane_q;

  logic aw_fire;
  logic w_fire;

  // ----------------------------------------
  // Address channel
  // ----------------------------------------

  always_comb begin
    narrow_aw       = wide_aw;
    narrow_aw.addr  = {wide_aw.addr[addr_width-1:word_lsb], {word_lsb{1'b0}}};
    narrow_aw.size  = size_t'(word_lsb);
    // Hold off AW until the data beat of the last one went through
    narrow_aw.valid = wide_aw.valid && (state_q == st_idle);
    wide_aw_ready   = narrow_aw_ready && (state_q == st_idle);
  end

  assign aw_fire = wide_aw.valid && wide_aw_ready;

  // ----------------------------------------
  // Write data lane select
  // ----------------------------------------

  always_comb begin
    narrow_w     = '0;
    // W stays blocked while idle, so data never overtakes its address
    wide_w_ready = 1'b0;
    if (state_q == st_single) begin
      narrow_w.data  = wide_w.data[lane_q*narrow_data_width +: narrow_data_width];
      narrow_w.strb  = wide_w.strb[lane_q*narrow_strb +: narrow_strb];
      narrow_w.last  = wide_w.last;
      narrow_w.valid = wide_w.valid;
      wide_w_ready   = narrow_w_ready;
    end
  end

  assign w_fire = narrow_w.valid && narrow_w_ready;

  // Write response goes straight back
  assign wide_b         = narrow_b;
  assign narrow_b_ready = wide_b_ready;

  // ----------------------------------------
  // FSM
  // ----------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (aw_fire) begin
          state_d = st_single;
        end
      end
      st_single: begin
        // Data beat accepted downstream
        if (w_fire) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      lane_q <= wide_aw.addr[word_lsb +: lane_bits];
    end
  end

endmodule

`default_nettype wire

/* source/axi_narrow_mem.sv */
// Narrow single-beat AXI memory with byte strobes and range check, used as the downsizer's subordinate
`default_nettype none

module axi_narrow_mem
  import axi_dw_pkg::*;
#(
  parameter int unsigned narrow_data_width = axi_dw_pkg::narrow_data_width,
  parameter int unsigned depth_words       = 64
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Read channels
  input  ax_req_t   ar,
  output logic      ar_ready,
  output narrow_r_t r,
  input  logic      r_ready,
  // Write channels
  input  ax_req_t   aw,
  output logic      aw_ready,
  input  narrow_w_t w,
  output logic      w_ready,
  output b_rsp_t    b,
  input  logic      b_ready
);

  localparam int unsigned word_lsb      = $clog2(narrow_data_width / 8);
  localparam int unsigned strb_width    = narrow_data_width / 8;
  // Word index taken from the full address
  localparam int unsigned idx_width     = addr_width - word_lsb;
  localparam int unsigned mem_idx_width = (depth_words > 1) ? $clog2(depth_words) : 1;

  typedef logic [narrow_data_width-1:0] word_t;
  typedef logic [idx_width-1:0]         idx_t;

  word_t mem_q [depth_words];

  // Read side
  logic  r_valid_q;
  id_t   r_id_q;
  word_t r_data_q;
  resp_t r_resp_q;
  idx_t  ar_idx;
  logic  ar_in_range;
  logic  ar_fire;
  logic  r_fire;

  // Write side
  logic  aw_held_q;
  id_t   aw_id_q;
  idx_t  aw_idx_q;
  logic  aw_in_range;
  logic  b_valid_q;
  id_t   b_id_q;
  resp_t b_resp_q;
  logic  aw_fire;
  logic  w_fire;
  logic  b_fire;

  // ----------------------------------------
  // Handshakes
  // ----------------------------------------

  // One read in flight, refused while R is pending
  assign ar_ready = !r_valid_q;
  assign ar_fire  = ar.valid && ar_ready;
  assign r_fire   = r_valid_q && r_ready;

  // AW held until W arrives, then B must drain
  assign aw_ready = !aw_held_q && !b_valid_q;
  assign w_ready  = aw_held_q;
  assign aw_fire  = aw.valid && aw_ready;
  assign w_fire   = w.valid && w_ready;
  assign b_fire   = b_valid_q && b_ready;

  // Range checks
  assign ar_idx      = ar.addr[addr_width-1:word_lsb];
  assign ar_in_range = 32'(ar_idx) < depth_words;
  assign aw_in_range = 32'(aw_idx_q) < depth_words;

  // ----------------------------------------
  // Control and storage
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
      aw_held_q <= 1'b0;
      b_valid_q <= 1'b0;
      for (int i = 0; i < depth_words; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (ar_fire) begin
        r_valid_q <= 1'b1;
      end else if (r_fire) begin
        r_valid_q <= 1'b0;
      end

      if (aw_fire) begin
        aw_held_q <= 1'b1;
      end else if (w_fire) begin
        aw_held_q <= 1'b0;
      end

      // B follows the W beat by one cycle
      if (w_fire) begin
        b_valid_q <= 1'b1;
      end else if (b_fire) begin
        b_valid_q <= 1'b0;
      end

      // Byte-wise write, dropped when out of range
      if (w_fire && aw_in_range) begin
        for (int j = 0; j < strb_width; j++) begin
          if (w.strb[j]) begin
            mem_q[aw_idx_q[mem_idx_width-1:0]][8*j +: 8] <= w.data[8*j +: 8];
          end
        end
      end
    end
  end

  // ----------------------------------------
  // Response payload
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      r_id_q <= ar.id;
      if (ar_in_range) begin
        r_data_q <= mem_q[ar_idx[mem_idx_width-1:0]];
        r_resp_q <= resp_okay;
      end else begin
        r_data_q <= '0;
        r_resp_q <= resp_slverr;
      end
    end
    if (aw_fire) begin
      aw_id_q  <= aw.id;
      aw_idx_q <= aw.addr[addr_width-1:word_lsb];
    end
    if (w_fire) begin
      b_id_q   <= aw_id_q;
      b_resp_q <= aw_in_range ? resp_okay : resp_slverr;
    end
  end

  // Single beat, so last is always set
  assign r.id    = r_id_q;
  assign r.data  = r_data_q;
  assign r.resp  = r_resp_q;
  assign r.last  = 1'b1;
  assign r.valid = r_valid_q;

  assign b.id    = b_id_q;
  assign b.resp  = b_resp_q;
  assign b.valid = b_valid_q;

endmodule

`default_nettype wire

/* source/axi_dw_top.sv */
// Top level of the downsizer; wide AXI port in, both paths and the narrow memory behind them
`default_nettype none

module axi_dw_top
  import axi_dw_pkg::*;
#(
  parameter int unsigned wide_data_width   = axi_dw_pkg::wide_data_width,
  parameter int unsigned narrow_data_width = axi_dw_pkg::narrow_data_width,
  parameter int unsigned mem_depth_words   = 64
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Wide read channels
  input  ax_req_t ar,
  output logic    ar_ready,
  output wide_r_t r,
  input  logic    r_ready,
  // Wide write channels
  input  ax_req_t aw,
  output logic    aw_ready,
  input  wide_w_t w,
  output logic    w_ready,
  output b_rsp_t  b,
  input  logic    b_ready
);

  // ----------------------------------------
  // Narrow side wires
  // ----------------------------------------

  ax_req_t   narrow_ar;
  logic      narrow_ar_ready;
  narrow_r_t narrow_r;
  logic      narrow_r_ready;

  ax_req_t   narrow_aw;
  logic      narrow_aw_ready;
  narrow_w_t narrow_w;
  logic      narrow_w_ready;
  b_rsp_t    narrow_b;
  logic      narrow_b_ready;

  // Read downsizer
  axi_dw_read_path #(
    .wide_data_width   (wide_data_width),
    .narrow_data_width (narrow_data_width)
  ) read_path_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wide_ar         (ar),
    .wide_ar_ready   (ar_ready),
    .wide_r          (r),
    .wide_r_ready    (r_ready),
    .narrow_ar       (narrow_ar),
    .narrow_ar_ready (narrow_ar_ready),
    .narrow_r        (narrow_r),
    .narrow_r_ready  (narrow_r_ready)
  );

  // Write downsizer
  axi_dw_write_path #(
    .wide_data_width   (wide_data_width),
    .narrow_data_width (narrow_data_width)
  ) write_path_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wide_aw         (aw),
    .wide_aw_ready   (aw_ready),
    .wide_w          (w),
    .wide_w_ready    (w_ready),
    .wide_b          (b),
    .wide_b_ready    (b_ready),
    .narrow_aw       (narrow_aw),
    .narrow_aw_ready (narrow_aw_ready),
    .narrow_w        (narrow_w),
    .narrow_w_ready  (narrow_w_ready),
    .narrow_b        (narrow_b),
    .narrow_b_ready  (narrow_b_ready)
  );

  // Narrow subordinate
  axi_narrow_mem #(
    .narrow_data_width (narrow_data_width),
    .depth_words       (mem_depth_words)
  ) narrow_mem_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .ar       (narrow_ar),
    .ar_ready (narrow_ar_ready),
    .r        (narrow_r),
    .r_ready  (narrow_r_ready),
    .aw       (narrow_aw),
    .aw_ready (narrow_aw_ready),
    .w        (narrow_w),
    .w_ready  (narrow_w_ready),
    .b        (narrow_b),
    .b_ready  (narrow_b_ready)
  );

endmodule

`default_nettype wire

/* bench/tb_axi_dw.sv */
// Table-driven testbench for the AXI downsizer top level with random R and B back-pressure
`default_nettype none

module tb_axi_dw
  import axi_dw_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned mem_depth    = 64;
  localparam int unsigned reset_cycles = 10;
  localparam int unsigned row_cycles   = 50;

  // One table row; expected read data is filled in from the reference array
  typedef struct packed {
    logic        is_write;
    logic        stall;
    addr_t       addr;
    logic [63:0] data;
    logic [7:0]  strb;
    logic [63:0] exp_data;
    resp_t       exp_resp;
  } row_t;

  logic    clk_i;
  logic    rst_ni;
  ax_req_t ar;
  logic    ar_ready;
  wide_r_t r;
  logic    r_ready;
  ax_req_t aw;
  logic    aw_ready;
  wide_w_t w;
  logic    w_ready;
  b_rsp_t  b;
  logic    b_ready;

  row_t        rows[$];
  string       names[$];
  logic [31:0] ref_mem [mem_depth];
  bit          table_done;
  bit          stall_en;
  int          sample_no;
  int          test_errors;
  int          err_count;
  int          pass_count;
  int          fail_count;

  axi_dw_top #(
    .wide_data_width   (64),
    .narrow_data_width (32),
    .mem_depth_words   (mem_depth)
  ) axi_dw_top_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .ar       (ar),
    .ar_ready (ar_ready),
    .r        (r),
    .r_ready  (r_ready),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w        (w),
    .w_ready  (w_ready),
    .b        (b),
    .b_ready  (b_ready)
  );

  // ----------------------------------------
  // Clock, ready stalls, watchdog
  // ----------------------------------------

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Random ready stalls on R and B, only for rows that ask for them
  initial begin
    void'($urandom(32'h7c99));
    r_ready = 1'b1;
    b_ready = 1'b1;
    forever begin
      @(posedge clk_i);
      #5;
      if (stall_en) begin
        r_ready = ($urandom % 4) != 0;
        b_ready = ($urandom % 4) != 0;
      end else begin
        r_ready = 1'b1;
        b_ready = 1'b1;
      end
    end
  end

  initial begin
    wait (table_done);
    repeat (reset_cycles + rows.size() * row_cycles) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles",
             reset_cycles + rows.size() * row_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Outputs are stable at the falling edge
  task automatic sample_point();
    @(negedge clk_i);
    sample_no++;
  endtask

  task automatic next_drive();
    @(posedge clk_i);
    #5;
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", test, what, exp, act);
      test_errors++;
      err_count++;
    end
  endtask

  task automatic add_row(input string name, input logic is_write, input logic stall,
                         input addr_t addr, input logic [63:0] data,
                         input logic [7:0] strb, input resp_t exp_resp);
    row_t row;
    row          = '0;
    row.is_write = is_write;
    row.stall    = stall;
    row.addr     = addr;
    row.data     = data;
    row.strb     = strb;
    row.exp_resp = exp_resp;
    rows.push_back(row);
    names.push_back(name);
  endtask

  // Wide beat that a read of addr should return
  function automatic logic [63:0] expected_read(input addr_t addr);
    int unsigned idx;
    logic [31:0] word;
    idx  = 32'(addr[15:2]);
    word = (idx < mem_depth) ? ref_mem[idx] : 32'h0;
    return addr[2] ? {word, 32'h0} : {32'h0, word};
  endfunction

  // Lane from address bit 2, then byte strobes within that lane
  task automatic update_ref(input row_t row);
    int unsigned idx;
    int unsigned lane;
    idx  = 32'(row.addr[15:2]);
    lane = 32'(row.addr[2]);
    if (idx < mem_depth) begin
      for (int j = 0; j < 4; j++) begin
        if (row.strb[lane*4 + j]) begin
          ref_mem[idx][8*j +: 8] = row.data[lane*32 + 8*j +: 8];
        end
      end
    end
  endtask

  // ----------------------------------------
  // Transfers
  // ----------------------------------------

  task automatic run_write(input int k);
    row_t   row;
    string  name;
    int     aw_at;
    int     w_at;
    bit     b_seen;
    bit     b_done;
    b_rsp_t b_held;
    row    = rows[k];
    name   = names[k];
    aw_at  = -1;
    w_at   = -1;
    b_seen = 1'b0;
    b_done = 1'b0;
    b_held = '0;
    aw       = '0;
    aw.id    = id_t'(k);
    aw.addr  = row.addr;
    aw.size  = 3'd2;
    aw.burst = burst_incr;
    aw.valid = 1'b1;
    // W offered together with AW, the path holds it back
    w       = '0;
    w.data  = row.data;
    w.strb  = row.strb;
    w.last  = 1'b1;
    w.valid = 1'b1;
    while (aw_at < 0 || w_at < 0) begin
      sample_point();
      if (aw.valid && aw_ready) begin
        aw_at = sample_no;
      end
      if (w.valid && w_ready) begin
        w_at = sample_no;
      end
      next_drive();
      if (aw_at >= 0) begin
        aw.valid = 1'b0;
      end
      if (w_at >= 0) begin
        w.valid = 1'b0;
      end
    end
    check_value(name, "w after aw", 128'(1), 128'(w_at - aw_at));
    while (!b_done) begin
      sample_point();
      if (b_seen) begin
        check_value(name, "b held", 128'(b_held), 128'(b));
      end else if (b.valid) begin
        b_seen = 1'b1;
        b_held = b;
        check_value(name, "b latency", 128'(1), 128'(sample_no - w_at));
      end
      if (b_seen && b_ready) begin
        b_done = 1'b1;
      end
      next_drive();
    end
    check_value(name, "b id", 128'(id_t'(k)), 128'(b_held.id));
    check_value(name, "b resp", 128'(row.exp_resp), 128'(b_held.resp));
    update_ref(row);
  endtask

  task automatic run_read(input int k);
    row_t    row;
    string   name;
    int      ar_at;
    bit      r_seen;
    bit      r_done;
    wide_r_t r_held;
    row    = rows[k];
    name   = names[k];
    ar_at  = -1;
    r_seen = 1'b0;
    r_done = 1'b0;
    r_held = '0;
    ar       = '0;
    ar.id    = id_t'(k);
    ar.addr  = row.addr;
    ar.size  = 3'd2;
    ar.burst = burst_incr;
    ar.valid = 1'b1;
    while (ar_at < 0) begin
      sample_point();
      if (ar.valid && ar_ready) begin
        ar_at = sample_no;
      end
      next_drive();
      if (ar_at >= 0) begin
        ar.valid = 1'b0;
      end
    end
    while (!r_done) begin
      sample_point();
      if (r_seen) begin
        check_value(name, "r held", 128'(r_held), 128'(r));
      end else if (r.valid) begin
        r_seen = 1'b1;
        r_held = r;
        check_value(name, "r latency", 128'(1), 128'(sample_no - ar_at));
      end
      if (r_seen && r_ready) begin
        r_done = 1'b1;
      end
      next_drive();
    end
    check_value(name, "r data", 128'(row.exp_data), 128'(r_held.data));
    check_value(name, "r resp", 128'(row.exp_resp), 128'(r_held.resp));
    check_value(name, "r id", 128'(id_t'(k)), 128'(r_held.id));
    check_value(name, "r last", 128'(1), 128'(r_held.last));
  endtask

  task automatic report_test(input string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("test %-18s ok", name);
    end else begin
      fail_count++;
      $display("test %-18s failed with %0d errors", name, test_errors);
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    row_t cur;
    rst_ni   = 1'b0;
    ar       = '0;
    aw       = '0;
    w        = '0;
    stall_en = 1'b0;
    for (int i = 0; i < mem_depth; i++) begin
      ref_mem[i] = 32'h0;
    end

    // Lane steering, strobes, range errors
    add_row("wr_lo_full",   1, 0, 16'h0010, 64'h11223344_55667788, 8'hff, resp_okay);
    add_row("rd_lo_full",   0, 0, 16'h0010, 64'h0, 8'h00, resp_okay);
    add_row("wr_hi_full",   1, 0, 16'h0014, 64'hcafef00d_deadbeef, 8'hff, resp_okay);
    add_row("rd_hi_full",   0, 0, 16'h0014, 64'h0, 8'h00, resp_okay);
    add_row("wr_lo_strb",   1, 0, 16'h0010, 64'haaaaaaaa_bbbbbbbb, 8'h05, resp_okay);
    add_row("rd_lo_strb",   0, 0, 16'h0010, 64'h0, 8'h00, resp_okay);
    add_row("wr_hi_strb",   1, 0, 16'h0014, 64'h99887766_00000000, 8'hc0, resp_okay);
    add_row("rd_hi_strb",   0, 0, 16'h0014, 64'h0, 8'h00, resp_okay);
    add_row("wr_off_lane",  1, 0, 16'h001c, 64'h12345678_9abcdef0, 8'h0f, resp_okay);
    add_row("rd_off_lane",  0, 0, 16'h001c, 64'h0, 8'h00, resp_okay);
    add_row("wr_oor",       1, 0, 16'h0100, 64'hffffffff_ffffffff, 8'hff, resp_slverr);
    add_row("rd_oor",       0, 0, 16'h0100, 64'h0, 8'h00, resp_slverr);
    add_row("rd_oor_top",   0, 0, 16'hfffc, 64'h0, 8'h00, resp_slverr);
    add_row("rd_no_alias",  0, 0, 16'h0000, 64'h0, 8'h00, resp_okay);
    // Same kinds of rows under R and B stalls
    add_row("wr_unaligned", 1, 1, 16'h0026, 64'h0badc0de_01020304, 8'hff, resp_okay);
    add_row("wr_last_word", 1, 1, 16'h00fc, 64'h76543210_fedcba98, 8'hff, resp_okay);
    add_row("wr_first",     1, 1, 16'h0000, 64'h00000000_a5a5a5a5, 8'h0f, resp_okay);
    add_row("rd_unaligned", 0, 1, 16'h0025, 64'h0, 8'h00, resp_okay);
    add_row("rd_last_word", 0, 1, 16'h00fc, 64'h0, 8'h00, resp_okay);
    add_row("rd_first",     0, 1, 16'h0000, 64'h0, 8'h00, resp_okay);
    add_row("rd_oor_stall", 0, 1, 16'h0104, 64'h0, 8'h00, resp_slverr);
    add_row("wr_oor_stall", 1, 1, 16'h01f8, 64'h01234567_89abcdef, 8'hff, resp_slverr);
    add_row("rd_lo_stall",  0, 1, 16'h0010, 64'h0, 8'h00, resp_okay);
    table_done = 1'b1;

    repeat (reset_cycles) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;

    // Idle state straight out of reset
    test_errors = 0;
    sample_point();
    check_value("reset_state", "ar_ready", 128'(1), 128'(ar_ready));
    check_value("reset_state", "aw_ready", 128'(1), 128'(aw_ready));
    check_value("reset_state", "w_ready", 128'(0), 128'(w_ready));
    check_value("reset_state", "r valid", 128'(0), 128'(r.valid));
    check_value("reset_state", "b valid", 128'(0), 128'(b.valid));
    report_test("reset_state");
    next_drive();

    for (int k = 0; k < rows.size(); k++) begin
      @(negedge clk_i);
      stall_en = rows[k].stall;
      next_drive();
      test_errors = 0;
      if (rows[k].is_write) begin
        run_write(k);
      end else begin
        cur          = rows[k];
        cur.exp_data = expected_read(cur.addr);
        rows[k]      = cur;
        run_read(k);
      end
      report_test(names[k]);
    end

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
source/axi_dw_pkg.sv
source/axi_dw_read_path.sv
source/axi_dw_write_path.sv
source/axi_narrow_mem.sv
source/axi_dw_top.sv
bench/tb_axi_dw.sv

/* run.sh */
#!/bin/sh
# Build the downsizer testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f src.f \
  --top-module tb_axi_dw \
  --Mdir obj_dir \
  -o tb_axi_dw

./obj_dir/tb_axi_dw > sim.log 2>&1
cat sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
